// ==== include/uart_tx_config.svh ====
`ifndef UART_TX_CONFIG_SVH
`define UART_TX_CONFIG_SVH

// Baud divisor width, bit time is up to 2**16-1 ticks
`define UART_DIV_W 16

// Widest data field, narrower frames are masked down
`define UART_MAX_DATA_BITS 8

// Smallest legal divisor
`define UART_MIN_DIV 2

`endif

// ==== hdl/uart_tx_pkg.sv ====
`include "uart_tx_config.svh"

package uart_tx_pkg;

    // Data field width, DB5 maps to 5 bits
    typedef enum logic [1:0] {
        DB5 = 2'b00,
        DB6 = 2'b01,
        DB7 = 2'b10,
        DB8 = 2'b11
    } data_bits_e;

    typedef enum logic {
        STOP1 = 1'b0,
        STOP2 = 1'b1
    } stop_bits_e;

    typedef enum logic {
        PAR_EVEN = 1'b0,
        PAR_ODD  = 1'b1
    } parity_e;

    // Frame configuration, 5 bits
    typedef struct packed {
        data_bits_e data_bits;
        stop_bits_e stop_bits;
        logic       parity_en;
        parity_e    parity_type;
    } uart_cfg_t;

    typedef logic [`UART_MAX_DATA_BITS-1:0] uart_data_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE       = 3'b000,
        START_BIT  = 3'b001,
        DATA_BITS  = 3'b010,
        PARITY_BIT = 3'b011,
        STOP_BITS  = 3'b100
    } tx_state_t;

    // Line level source for the output flop
    typedef enum logic [1:0] {
        LINE_IDLE   = 2'b00,
        LINE_START  = 2'b01,
        LINE_DATA   = 2'b10,
        LINE_PARITY = 2'b11
    } line_sel_e;

    typedef struct packed {
        logic      load;     // Capture byte and parity
        logic      shift;    // Advance to next data bit
        line_sel_e line_sel; // Level for the coming bit
    } tx_phase_t;

endpackage

// ==== hdl/baud_gen.sv ====
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module baud_gen (
    input  logic                   tick_i,
    input  logic                   reset_n,
    input  logic                   run_i,         // High for the whole frame
    input  logic [`UART_DIV_W-1:0] div_i,         // Ticks per bit
    output logic                   bit_strobe_o   // Last tick of each bit
);

    logic [`UART_DIV_W-1:0] div_q;     // Divisor frozen for the frame
    logic [`UART_DIV_W-1:0] cnt_q;
    logic [`UART_DIV_W-1:0] last_cnt;
    logic                   cnt_wrap;

    //////////////////////////////
    // Divisor capture
    //////////////////////////////

    // Follows div_i while idle, so the value on the start edge sticks
    always_ff @(posedge tick_i) begin
        if (!run_i)
            div_q <= div_i;
    end

    assign last_cnt = div_q - 1'b1;
    assign cnt_wrap = (cnt_q == last_cnt);

    //////////////////////////////
    // Tick counter
    //////////////////////////////

    always_ff @(posedge tick_i or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= '0;
        end else if (!run_i || cnt_wrap) begin
            cnt_q <= '0;                  // Idle clear or start of next bit
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign bit_strobe_o = run_i && cnt_wrap;  // Never fires while idle

endmodule

// ==== hdl/tx_frame_fsm.sv ====
`timescale 1ns/1ps

module tx_frame_fsm (
    input  logic                   tick_i,
    input  logic                   reset_n,
    input  logic                   start_i,       // Host strobe
    input  uart_tx_pkg::uart_cfg_t cfg_i,
    input  logic                   bit_strobe_i,  // End of current bit
    output logic                   run_o,         // Enables the divider
    output uart_tx_pkg::tx_phase_t phase_o,       // Steers the shifter
    output logic                   busy_o,
    output logic                   done_o
);

    import uart_tx_pkg::*;

    tx_state_t  state_q;
    tx_state_t  state_d;
    uart_cfg_t  cfg_q;          // Config of the frame in flight
    logic [2:0] bit_cnt_q;      // Data or stop bit index
    logic [2:0] bit_cnt_d;
    logic [2:0] data_last;
    logic [2:0] stop_last;
    logic       accept;
    logic       frame_end;
    logic       busy_q;
    logic       done_q;

    // Starts outside IDLE are dropped silently
    assign accept = (state_q == IDLE) && start_i;

    // DB5..DB8 gives index 4..7 for the last data bit
    assign data_last = 3'd4 + {1'b0, cfg_q.data_bits};
    assign stop_last = {2'b00, cfg_q.stop_bits};   // 0 or 1

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_d   = state_q;
        bit_cnt_d = bit_cnt_q;
        frame_end = 1'b0;
        case (state_q)
            IDLE: begin
                bit_cnt_d = '0;
                if (start_i)
                    state_d = START_BIT;
            end
            START_BIT: begin
                if (bit_strobe_i) begin
                    state_d   = DATA_BITS;
                    bit_cnt_d = '0;
                end
            end
            DATA_BITS: begin
                if (bit_strobe_i) begin
                    if (bit_cnt_q == data_last) begin
                        // Parity phase only when enabled
                        state_d   = cfg_q.parity_en ? PARITY_BIT : STOP_BITS;
                        bit_cnt_d = '0;
                    end else begin
                        bit_cnt_d = bit_cnt_q + 3'd1;
                    end
                end
            end
            PARITY_BIT: begin
                if (bit_strobe_i) begin
                    state_d   = STOP_BITS;
                    bit_cnt_d = '0;
                end
            end
            STOP_BITS: begin
                if (bit_strobe_i) begin
                    if (bit_cnt_q == stop_last) begin
                        state_d   = IDLE;
                        frame_end = 1'b1;    // Last stop bit done
                    end else begin
                        bit_cnt_d = bit_cnt_q + 3'd1;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    //////////////////////////////
    // Phase to shifter
    //////////////////////////////

    // Line select follows the next state so tx_o moves with the state
    always_comb begin
        phase_o.load  = accept;
        phase_o.shift = (state_q == DATA_BITS) && bit_strobe_i;
        case (state_d)
            START_BIT:  phase_o.line_sel = LINE_START;
            DATA_BITS:  phase_o.line_sel = LINE_DATA;
            PARITY_BIT: phase_o.line_sel = LINE_PARITY;
            default:    phase_o.line_sel = LINE_IDLE;   // Idle and stop are high
        endcase
    end

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge tick_i or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            cfg_q     <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            bit_cnt_q <= bit_cnt_d;
            if (accept)
                cfg_q <= cfg_i;               // Held for the whole frame
            busy_q    <= (state_d != IDLE);
            done_q    <= frame_end;           // One tick, as busy falls
        end
    end

    assign run_o  = (state_q != IDLE);
    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

// ==== hdl/tx_shift_reg.sv ====
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module tx_shift_reg (
    input  logic                           tick_i,
    input  logic                           reset_n,
    input  logic [`UART_MAX_DATA_BITS-1:0] data_i,   // Raw host byte
    input  uart_tx_pkg::uart_cfg_t         cfg_i,    // Valid on the load edge
    input  uart_tx_pkg::tx_phase_t         phase_i,
    output logic                           tx_o      // Serial line
);

    import uart_tx_pkg::*;

    uart_data_t data_mask;
    uart_data_t data_masked;
    uart_data_t shift_q;
    uart_data_t shift_d;
    logic       parity_calc;
    logic       parity_q;       // Parity of the loaded byte
    logic       tx_d;
    logic       tx_q;

    //////////////////////////////
    // Masking and parity
    //////////////////////////////

    // Keep the low 5..8 bits
    always_comb begin
        for (int i = 0; i < `UART_MAX_DATA_BITS; i++) begin
            data_mask[i] = (i < (int'(cfg_i.data_bits) + 5));
        end
    end

    assign data_masked = data_i & data_mask;

    // Even parity is plain XOR, odd flips it
    assign parity_calc = (^data_masked) ^ (cfg_i.parity_type == PAR_ODD);

    //////////////////////////////
    // Shifter and line select
    //////////////////////////////

    always_comb begin
        if (phase_i.load)
            shift_d = data_masked;
        else if (phase_i.shift)
            shift_d = shift_q >> 1;           // LSB first
        else
            shift_d = shift_q;
    end

    // Look at the updated register so the new data bit lands on this edge
    always_comb begin
        case (phase_i.line_sel)
            LINE_START:  tx_d = 1'b0;
            LINE_DATA:   tx_d = shift_d[0];
            LINE_PARITY: tx_d = parity_q;
            default:     tx_d = 1'b1;         // Idle and stop
        endcase
    end

    always_ff @(posedge tick_i) begin
        shift_q <= shift_d;
        if (phase_i.load)
            parity_q <= parity_calc;
    end

    always_ff @(posedge tick_i or negedge reset_n) begin
        if (!reset_n)
            tx_q <= 1'b1;                     // Line idles high
        else
            tx_q <= tx_d;
    end

    assign tx_o = tx_q;

endmodule

// ==== hdl/uart_tx_top.sv ====
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module uart_tx_top (
    input  logic                           tick_i,
    input  logic                           reset_n,
    input  logic                           tx_start_i,   // Ignored while busy
    input  logic [`UART_MAX_DATA_BITS-1:0] data_i,
    input  uart_tx_pkg::uart_cfg_t         cfg_i,        // Sampled on acceptance
    input  logic [`UART_DIV_W-1:0]         baud_div_i,   // Ticks per bit, min 2
    output logic                           tx_o,
    output logic                           busy_o,
    output logic                           done_o        // One tick at frame end
);

    import uart_tx_pkg::*;

    logic      run;           // Divider enable
    logic      bit_strobe;    // Bit boundary
    tx_phase_t phase;         // Sequencer to shifter

    //////////////////////////////
    // Bit timing
    //////////////////////////////

    baud_gen i_baud_gen (
        .tick_i       (tick_i),
        .reset_n      (reset_n),
        .run_i        (run),
        .div_i        (baud_div_i),
        .bit_strobe_o (bit_strobe)
    );

    //////////////////////////////
    // Frame sequencing
    //////////////////////////////

    tx_frame_fsm i_tx_frame_fsm (
        .tick_i       (tick_i),
        .reset_n      (reset_n),
        .start_i      (tx_start_i),
        .cfg_i        (cfg_i),
        .bit_strobe_i (bit_strobe),
        .run_o        (run),
        .phase_o      (phase),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    //////////////////////////////
    // Data path
    //////////////////////////////

    // Loads on the same edge the sequencer accepts the start
    tx_shift_reg i_tx_shift_reg (
        .tick_i  (tick_i),
        .reset_n (reset_n),
        .data_i  (data_i),
        .cfg_i   (cfg_i),
        .phase_i (phase),
        .tx_o    (tx_o)
    );

endmodule

// ==== dv/uart_tx_tb.sv ====
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module uart_tx_tb;

    import uart_tx_pkg::*;

    localparam int TICK_NS     = 40;
    localparam int NUM_FRAMES  = 62;
    localparam int FRAME_TICKS = 12 * 16;      // Longest frame at the slowest divisor
    // Worst case frames plus reset and idle gaps
    localparam int WATCHDOG_NS = (NUM_FRAMES * FRAME_TICKS + 2000) * TICK_NS;
    localparam int TIMING_DIVS [6] = '{2, 3, 5, 8, 13, 16};

    logic                           tick_i;
    logic                           reset_n;
    logic                           tx_start_i;
    logic [`UART_MAX_DATA_BITS-1:0] data_i;
    uart_cfg_t                      cfg_i;
    logic [`UART_DIV_W-1:0]         baud_div_i;
    logic                           tx_o;
    logic                           busy_o;
    logic                           done_o;

    logic  exp_bits [0:11];    // Expected line level per bit
    int    exp_len;
    string test_name;
    int    checks       = 0;
    int    errors       = 0;
    int    test_errors  = 0;   // Error count when the test began
    int    tests_passed = 0;
    int    tests_failed = 0;

    uart_tx_top i_uart_tx_top (
        .tick_i     (tick_i),
        .reset_n    (reset_n),
        .tx_start_i (tx_start_i),
        .data_i     (data_i),
        .cfg_i      (cfg_i),
        .baud_div_i (baud_div_i),
        .tx_o       (tx_o),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    initial begin
        tick_i = 1'b0;
        forever #(TICK_NS / 2) tick_i = ~tick_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run never finished", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////
    // Checks and bookkeeping
    //////////////////////////////

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s %s: expected %b, actual %b",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("[PASS] %s", test_name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s with %0d errors", test_name, errors - test_errors);
        end
    endtask

    // Line high with busy and done low for a number of ticks
    task automatic check_idle(input int ticks);
        repeat (ticks) begin
            @(negedge tick_i);
            check_bit("tx_o idle", 1'b1, tx_o);
            check_bit("busy_o idle", 1'b0, busy_o);
            check_bit("done_o idle", 1'b0, done_o);
        end
    endtask

    function automatic uart_cfg_t random_cfg();
        logic [31:0] raw;
        raw = $urandom();
        return uart_cfg_t'(raw[4:0]);
    endfunction

    function automatic int random_div();
        return int'($urandom_range(16, `UART_MIN_DIV));
    endfunction

    //////////////////////////////
    // Frame model
    //////////////////////////////

    // Start low, LSB first data, optional parity, stop bits high
    task automatic build_frame(input logic [7:0] data, input uart_cfg_t cfg);
        int   width;
        logic par;
        case (cfg.data_bits)
            DB5:     width = 5;
            DB6:     width = 6;
            DB7:     width = 7;
            default: width = 8;
        endcase
        par     = 1'b0;
        exp_len = 0;
        exp_bits[exp_len++] = 1'b0;
        for (int i = 0; i < width; i++) begin
            exp_bits[exp_len++] = data[i];
            par ^= data[i];
        end
        if (cfg.parity_en)
            exp_bits[exp_len++] = (cfg.parity_type == PAR_ODD) ? ~par : par;
        exp_bits[exp_len++] = 1'b1;
        if (cfg.stop_bits == STOP2)
            exp_bits[exp_len++] = 1'b1;
    endtask

    //////////////////////////////
    // Driver and line monitor
    //////////////////////////////

    // Called on a falling edge and returns on the falling edge where busy_o is low
    task automatic run_frame(input logic [7:0] data, input uart_cfg_t cfg, input int div,
                             input bit inject);
        int k;
        int start_k;
        int bit_idx;
        int busy_ticks;
        int inject_k;
        int limit;
        bit start_seen;
        bit running;
        build_frame(data, cfg);
        k          = 0;
        start_k    = 0;
        bit_idx    = 0;
        busy_ticks = 0;
        start_seen = 1'b0;
        running    = 1'b1;
        limit      = exp_len * div + 4;
        inject_k   = (exp_len * div) / 2;         // Roughly mid-frame
        data_i     = data;
        cfg_i      = cfg;
        baud_div_i = `UART_DIV_W'(div);
        tx_start_i = 1'b1;                        // Taken on the next rising edge
        while (running) begin
            @(negedge tick_i);
            k++;
            if (k == 1 || (inject && k == inject_k + 1))
                tx_start_i = 1'b0;
            if (inject && k == inject_k) begin
                data_i     = ~data;               // Must never reach the line
                cfg_i      = uart_cfg_t'(~cfg);
                baud_div_i = `UART_DIV_W'(div + 3);
                tx_start_i = 1'b1;
            end
            if (!start_seen && tx_o === 1'b0) begin
                start_seen = 1'b1;
                start_k    = k;
                check_count("start bit tick", 1, k);   // Low right after acceptance
            end
            // Middle of bit bit_idx
            if (start_seen && bit_idx < exp_len && k == start_k + bit_idx * div + div / 2) begin
                check_bit($sformatf("bit %0d", bit_idx), exp_bits[bit_idx], tx_o);
                bit_idx++;
            end
            if (busy_o !== 1'b1) begin
                running = 1'b0;
            end else begin
                busy_ticks++;
                check_bit("done_o inside frame", 1'b0, done_o);
                assert (k <= limit) else begin
                    errors++;
                    $display("%s: busy_o still high %0d ticks after the start", test_name, k);
                    running = 1'b0;
                end
            end
        end
        assert (start_seen) else begin
            errors++;
            $display("%s: tx_o never went low for a start bit", test_name);
        end
        check_count("bits on line", exp_len, bit_idx);
        check_count("busy ticks", exp_len * div, busy_ticks);
        check_bit("done_o at busy fall", 1'b1, done_o);
        check_bit("tx_o after stop", 1'b1, tx_o);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        uart_cfg_t  cfg;
        uart_cfg_t  cfg2;
        logic [7:0] data;
        int         div;
        void'($urandom(24));
        tx_start_i = 1'b0;
        data_i     = '0;
        cfg_i      = '0;
        baud_div_i = `UART_DIV_W'(2);
        reset_n    = 1'b0;
        repeat (10) @(negedge tick_i);
        reset_n    = 1'b1;

        start_test("reset_state");
        check_idle(20);                           // No start pulse yet
        finish_test();

        start_test("data_framing");
        for (int i = 0; i < 24; i++) begin
            cfg           = random_cfg();
            cfg.data_bits = data_bits_e'(i % 4);  // Walk all widths
            data          = 8'($urandom());
            run_frame(data, cfg, random_div(), 1'b0);
            check_idle(1);
        end
        finish_test();

        start_test("parity");
        for (int i = 0; i < 16; i++) begin
            cfg             = random_cfg();
            cfg.parity_en   = ((i % 4) != 3);     // Every fourth frame without parity
            cfg.parity_type = parity_e'(i % 2);
            data            = 8'($urandom());
            run_frame(data, cfg, random_div(), 1'b0);
            check_idle(1);
        end
        finish_test();

        start_test("frame_timing");
        for (int j = 0; j < 6; j++) begin
            for (int s = 0; s < 2; s++) begin
                cfg           = random_cfg();
                cfg.stop_bits = stop_bits_e'(s);
                data          = 8'($urandom());
                run_frame(data, cfg, TIMING_DIVS[j], 1'b0);
                check_idle(1);
            end
        end
        finish_test();

        start_test("start_while_busy");
        for (int i = 0; i < 4; i++) begin
            cfg  = random_cfg();
            data = 8'($urandom());
            div  = random_div();
            run_frame(data, cfg, div, 1'b1);
            check_idle(2 * div + 8);              // No second frame may follow
        end
        finish_test();

        start_test("back_to_back");
        for (int i = 0; i < 3; i++) begin
            cfg            = random_cfg();
            cfg2           = random_cfg();
            cfg2.data_bits = data_bits_e'(cfg.data_bits + 2'd1);   // Force a new width
            data           = 8'($urandom());
            run_frame(data, cfg, random_div(), 1'b0);
            data = 8'($urandom());
            run_frame(data, cfg2, random_div(), 1'b0);   // Starts while done_o is high
            check_idle(1);
        end
        finish_test();

        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/uart_tx_pkg.sv
hdl/baud_gen.sv
hdl/tx_frame_fsm.sv
hdl/tx_shift_reg.sv
hdl/uart_tx_top.sv
dv/uart_tx_tb.sv
